// ==== bpred.f ====
src/rv_pkg.sv
src/bpred_pkg.sv
src/branch_resolve.sv
src/pattern_history.sv
src/target_buffer.sv
src/fetch_predict.sv
src/bpred_top.sv
tb/tb_clock.sv
tb/bpred_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the branch predictor

VERILATOR ?= verilator
TOP       ?= bpred_tb
RTL_TOP   ?= bpred_top
FILELIST  ?= bpred.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= src/rv_pkg.sv src/bpred_pkg.sv src/branch_resolve.sv \
             src/pattern_history.sv src/target_buffer.sv src/fetch_predict.sv \
             src/bpred_top.sv
TB_SRCS   ?= tb/tb_clock.sv tb/bpred_tb.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/bpred_tb.sv ====
// ####################################################################
// bpred_tb
// Directed tests of the gshare predictor, checked against a behavioral
// model of the counters, target buffer entries and global history.
// ####################################################################

module bpred_tb;
  import rv_pkg::*;
  import bpred_pkg::*;

  localparam int    INDEX_BITS  = DEFAULT_INDEX_BITS;
  localparam int    ENTRIES     = 1 << INDEX_BITS;
  localparam int    TIMEOUT     = 40;            // cycles allowed per wait loop
  localparam xlen_t BRANCH_PC   = 32'h0000_0400;
  localparam xlen_t BRANCH_IMM  = 32'h0000_0100;
  localparam xlen_t BRANCH_DEST = 32'h0000_0500; // BRANCH_PC + BRANCH_IMM
  localparam xlen_t ALIAS_PC    = BRANCH_PC + ENTRIES * WORD_BYTES;  // same index, other tag
  localparam xlen_t REFILL_PC   = BRANCH_PC ^ 32'h0000_000c;         // never hits BRANCH_PC slot

  logic     clk;
  logic     reset;
  xlen_t    fetch_pc;
  logic     stall;
  resolve_t resolve;
  xlen_t    predict_pc;
  logic     redirect;
  xlen_t    redirect_pc;

  // reference model of the tables
  counter_e              m_ctr    [ENTRIES];
  logic                  m_valid  [ENTRIES];
  xlen_t                 m_tag    [ENTRIES];
  xlen_t                 m_target [ENTRIES];
  logic [INDEX_BITS-1:0] m_hist;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(10)) u_clock (.clk(clk), .reset(reset));

  bpred_top #(
    .INDEX_BITS (INDEX_BITS)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .stall       (stall),
    .resolve     (resolve),
    .predict_pc  (predict_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input xlen_t got, input xlen_t expected);
    assert (got === expected)
      else begin
        $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end_with_failure();
      end
  endtask

  function automatic resolve_t pack_resolve(input logic valid, input opcode_e op,
                                            input xlen_t pc, input xlen_t rs1,
                                            input xlen_t imm, input logic bcond,
                                            input xlen_t next_pc);
    resolve_t r;
    r.valid    = valid;
    r.opcode   = op;
    r.pc       = pc;
    r.rs1_data = rs1;
    r.imm      = imm;
    r.bcond    = bcond;
    r.next_pc  = next_pc;
    return r;
  endfunction

  function automatic resolve_t no_resolve();
    return pack_resolve(1'b0, other_op, '0, '0, '0, 1'b0, '0);
  endfunction

  function automatic logic [INDEX_BITS-1:0] table_index(input xlen_t pc);
    return INDEX_BITS'(pc / WORD_BYTES) ^ m_hist;
  endfunction

  function automatic logic is_control(input resolve_t r);
    return r.opcode == jal_op || r.opcode == jalr_op || r.opcode == branch_op;
  endfunction

  function automatic logic is_taken(input resolve_t r);
    return r.opcode == jal_op || r.opcode == jalr_op || (r.opcode == branch_op && r.bcond);
  endfunction

  function automatic xlen_t resolved_target(input resolve_t r);
    xlen_t t;
    t = r.pc + WORD_BYTES;
    if (r.opcode == jal_op || (r.opcode == branch_op && r.bcond))
      t = r.pc + r.imm;
    else if (r.opcode == jalr_op)
      t = r.rs1_data + r.imm;
    return t;
  endfunction

  function automatic xlen_t expected_predict(input xlen_t pc, input logic s);
    logic [INDEX_BITS-1:0] idx;
    idx = table_index(pc);
    if (s)
      return pc;
    if (m_valid[idx] && m_tag[idx] == pc &&
        (m_ctr[idx] == weakly_taken || m_ctr[idx] == strongly_taken))
      return m_target[idx];
    return pc + WORD_BYTES;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < ENTRIES; i++) begin
      m_ctr[i]    = strongly_not;
      m_valid[i]  = 1'b0;
      m_tag[i]    = '0;
      m_target[i] = '0;
    end
    m_hist = '0;
  endtask

  // mirrors the write the dut does at the coming edge
  task automatic update_model(input resolve_t r);
    logic [INDEX_BITS-1:0] idx;
    logic                  taken;
    if (r.valid && is_control(r)) begin
      idx   = table_index(r.pc);
      taken = is_taken(r);
      if (taken) begin
        m_ctr[idx]    = (m_ctr[idx] == strongly_not) ? weakly_not : strongly_taken;
        m_valid[idx]  = 1'b1;
        m_tag[idx]    = r.pc;
        m_target[idx] = resolved_target(r) & ~32'h3;  // stored as word address
      end else begin
        m_ctr[idx] = (m_ctr[idx] == strongly_taken) ? weakly_taken : strongly_not;
      end
      m_hist = {m_hist[INDEX_BITS-2:0], taken};
    end
  endtask

  task automatic drive_cycle(input xlen_t pc, input logic s, input resolve_t r);
    @(posedge clk);
    #1;
    fetch_pc = pc;
    stall    = s;
    resolve  = r;
    #4;  // mid cycle, outputs settled
    check_value("predict_pc", predict_pc, expected_predict(pc, s));
    check_value("redirect", xlen_t'(redirect),
                xlen_t'(r.valid && resolved_target(r) != r.next_pc));
    if (r.valid)
      check_value("redirect_pc", redirect_pc, resolved_target(r));
    update_model(r);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("reset was never released");
        end_with_failure();
      end
    end
  endtask

  task automatic reset_predictions();
    xlen_t pc;
    for (int i = 0; i < 8; i++) begin
      pc = $urandom & ~32'h3;
      drive_cycle(pc, 1'b0, no_resolve());
      check_value("predict_pc", predict_pc, pc + WORD_BYTES);
      drive_cycle(pc, 1'b1, no_resolve());
      check_value("predict_pc", predict_pc, pc);  // held during stall
    end
  endtask

  task automatic expect_resolution(input resolve_t r, input xlen_t dest, input logic redir);
    drive_cycle(32'h0000_2000, 1'b0, r);
    check_value("redirect_pc", redirect_pc, dest);
    check_value("redirect", xlen_t'(redirect), xlen_t'(redir));
  endtask

  task automatic resolve_targets();
    xlen_t pc;
    pc = 32'h0000_1000;
    expect_resolution(pack_resolve(1, jal_op, pc, '0, 32'h40, 0, pc + 4), 32'h1040, 1);
    expect_resolution(pack_resolve(1, jalr_op, pc, 32'h2000, 32'h8, 0, 32'h2008), 32'h2008, 0);
    expect_resolution(pack_resolve(1, branch_op, pc, '0, 32'hffff_fff0, 1, pc + 4),
                      32'h0ff0, 1);
    expect_resolution(pack_resolve(1, branch_op, pc, '0, 32'h80, 0, pc + 4), 32'h1004, 0);
    expect_resolution(pack_resolve(1, other_op, pc, '0, 32'h80, 0, 32'h3000), 32'h1004, 1);
    expect_resolution(pack_resolve(1, other_op, pc, '0, 32'h80, 0, pc + 4), 32'h1004, 0);
  endtask

  task automatic train_taken();
    int                    cycles;
    logic [INDEX_BITS-1:0] idx;
    resolve_t              r;
    cycles = 0;
    idx    = INDEX_BITS'(BRANCH_PC / WORD_BYTES) ^ {INDEX_BITS{1'b1}};
    r      = pack_resolve(1, branch_op, BRANCH_PC, '0, BRANCH_IMM, 1, BRANCH_PC + 4);
    while (!(m_hist == {INDEX_BITS{1'b1}} && m_ctr[idx] == strongly_taken)) begin
      drive_cycle(BRANCH_PC, 1'b0, r);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("branch training did not saturate history and counter");
        end_with_failure();
      end
    end
    drive_cycle(BRANCH_PC, 1'b0, no_resolve());
    check_value("predict_pc", predict_pc, BRANCH_DEST);
    drive_cycle(ALIAS_PC, 1'b0, no_resolve());
    check_value("predict_pc", predict_pc, ALIAS_PC + WORD_BYTES);  // tag miss
  endtask

  // taken jumps elsewhere until history is all ones again
  task automatic refill_history();
    int cycles;
    cycles = 0;
    while (m_hist != {INDEX_BITS{1'b1}}) begin
      drive_cycle(BRANCH_PC, 1'b0,
                  pack_resolve(1, jal_op, REFILL_PC, '0, 32'h20, 0, REFILL_PC + 32'h20));
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("history did not refill to all ones");
        end_with_failure();
      end
    end
  endtask

  task automatic train_not_taken();
    resolve_t r;
    r = pack_resolve(1, branch_op, BRANCH_PC, '0, BRANCH_IMM, 0, BRANCH_PC + 4);
    drive_cycle(BRANCH_PC, 1'b0, r);
    refill_history();
    drive_cycle(BRANCH_PC, 1'b0, no_resolve());
    check_value("predict_pc", predict_pc, BRANCH_DEST);  // weakly_taken still taken
    // plain instructions must not shift history or touch the taken entry
    for (int i = 0; i < 4; i++) begin
      drive_cycle(BRANCH_PC, 1'b0,
                  pack_resolve(1, other_op, 32'h800 + i * 4, '0, '0, 1, 32'h804 + i * 4));
      check_value("predict_pc", predict_pc, BRANCH_DEST);
    end
    drive_cycle(BRANCH_PC, 1'b0, r);
    refill_history();
    drive_cycle(BRANCH_PC, 1'b0, no_resolve());
    check_value("predict_pc", predict_pc, BRANCH_PC + WORD_BYTES);
  endtask

  task automatic random_mix();
    xlen_t    pool [8];
    xlen_t    pc;
    opcode_e  op;
    resolve_t r;
    for (int i = 0; i < 8; i++)
      pool[i] = 32'h1000 + ($urandom_range(0, 63) << 2);
    for (int n = 0; n < 300; n++) begin
      pc = pool[$urandom_range(0, 7)];
      case ($urandom_range(0, 3))
        0:       op = jal_op;
        1:       op = jalr_op;
        2:       op = branch_op;
        default: op = other_op;
      endcase
      r = pack_resolve($urandom_range(0, 3) != 0, op, pool[$urandom_range(0, 7)],
                       pool[$urandom_range(0, 7)], ($urandom_range(0, 63) << 2) - 128,
                       $urandom_range(0, 1), '0);
      r.next_pc = $urandom_range(0, 1) ? resolved_target(r) : r.pc + WORD_BYTES;
      drive_cycle(pc, $urandom_range(0, 7) == 0, r);
    end
  endtask

  initial begin
    void'($urandom(29158));
    fetch_pc = '0;
    stall    = 1'b0;
    resolve  = no_resolve();
    clear_model();
    wait_reset_release();
    reset_predictions();
    resolve_targets();
    train_taken();
    train_not_taken();
    random_mix();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
// ####################################################################
// tb_clock
// Free running testbench clock and a synchronous reset held for a
// fixed number of cycles.
// ####################################################################

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;  // released just after an edge
  end

endmodule

// ==== src/bpred_top.sv ====
// ####################################################################
// bpred_top
// Gshare branch predictor: resolution side, counter table with global
// history, tagged target buffer and next fetch pc selection.
// ####################################################################

module bpred_top #(
  parameter int INDEX_BITS = bpred_pkg::DEFAULT_INDEX_BITS
) (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::xlen_t    fetch_pc,
  input  logic             stall,
  input  rv_pkg::resolve_t resolve,
  output rv_pkg::xlen_t    predict_pc,
  output logic             redirect,
  output rv_pkg::xlen_t    redirect_pc
);
  import rv_pkg::*;
  import bpred_pkg::*;

  update_t               update;        // resolve to both tables
  logic [INDEX_BITS-1:0] lookup_index;
  logic [INDEX_BITS-1:0] update_index;
  counter_e              pred_counter;
  logic                  target_hit;
  xlen_t                 target_addr;
  lookup_t               lookup;

  branch_resolve u_resolve (
    .resolve     (resolve),
    .update      (update),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  pattern_history #(
    .INDEX_BITS (INDEX_BITS)
  ) u_history (
    .clk          (clk),
    .reset        (reset),
    .fetch_pc     (fetch_pc),
    .update       (update),
    .lookup_index (lookup_index),
    .update_index (update_index),
    .pred_counter (pred_counter)
  );

  // shares the gshare indices computed next to the history
  target_buffer #(
    .INDEX_BITS (INDEX_BITS)
  ) u_btb (
    .clk          (clk),
    .reset        (reset),
    .fetch_pc     (fetch_pc),
    .lookup_index (lookup_index),
    .update_index (update_index),
    .update       (update),
    .target_hit   (target_hit),
    .target_addr  (target_addr)
  );

  assign lookup = '{hit: target_hit, counter: pred_counter, target: target_addr};

  fetch_predict u_fetch (
    .fetch_pc   (fetch_pc),
    .stall      (stall),
    .lookup     (lookup),
    .predict_pc (predict_pc)
  );

endmodule

// ==== src/fetch_predict.sv ====
// ####################################################################
// fetch_predict
// Picks the next fetch pc from the table lookup. Holds the pc during
// a stall.
// ####################################################################

module fetch_predict (
  input  rv_pkg::xlen_t      fetch_pc,
  input  logic               stall,
  input  bpred_pkg::lookup_t lookup,
  output rv_pkg::xlen_t      predict_pc
);
  import rv_pkg::*;
  import bpred_pkg::*;

  logic predict_taken;

  // upper half of the counter range predicts taken
  assign predict_taken = lookup.hit &&
                         (lookup.counter == weakly_taken || lookup.counter == strongly_taken);

  always_comb begin
    if (stall)
      predict_pc = fetch_pc;  // fetch frozen
    else if (predict_taken)
      predict_pc = lookup.target;
    else
      predict_pc = fetch_pc + WORD_BYTES;
  end

endmodule

// ==== src/target_buffer.sv ====
// ####################################################################
// target_buffer
// Tagged branch target buffer. Looked up at fetch, written with the
// target and full pc tag on every taken resolve.
// ####################################################################

module target_buffer #(
  parameter int INDEX_BITS = bpred_pkg::DEFAULT_INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_pkg::xlen_t         fetch_pc,
  input  logic [INDEX_BITS-1:0] lookup_index,
  input  logic [INDEX_BITS-1:0] update_index,
  input  bpred_pkg::update_t    update,
  output logic                  target_hit,
  output rv_pkg::xlen_t         target_addr
);
  import rv_pkg::*;

  localparam int ENTRIES  = 1 << INDEX_BITS;
  localparam int WORD_LSB = $clog2(WORD_BYTES);

  typedef struct packed {
    xlen_t                    tag;          // full pc of the branch
    logic [XLEN-1:WORD_LSB]   target_word;  // target as a word address
  } entry_t;

  entry_t             entries [ENTRIES];
  logic [ENTRIES-1:0] valid;
  logic               write_en;
  entry_t             hit_entry;

  assign write_en = update.valid && update.taken;

  always_ff @(posedge clk) begin
    if (reset)
      valid <= '0;
    else if (write_en)
      valid[update_index] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (write_en)
      entries[update_index] <= '{tag: update.pc, target_word: update.target[XLEN-1:WORD_LSB]};
  end

  assign hit_entry   = entries[lookup_index];
  assign target_hit  = valid[lookup_index] && (hit_entry.tag == fetch_pc);
  assign target_addr = {hit_entry.target_word, {WORD_LSB{1'b0}}};

  // not-taken and non-control resolves leave every entry alone
  assert property (@(posedge clk) disable iff (reset)
    !(update.valid && update.taken) |=>
      valid == $past(valid) &&
      entries[$past(update_index)] === $past(entries[update_index]))
    else $error("btb entry written without a taken update");

endmodule

// ==== src/pattern_history.sv ====
// ####################################################################
// pattern_history
// Global history register and two-bit counter table. Both indices are
// the pc word address xor the history from before the update edge.
// ####################################################################

module pattern_history #(
  parameter int INDEX_BITS = bpred_pkg::DEFAULT_INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_pkg::xlen_t         fetch_pc,
  input  bpred_pkg::update_t    update,
  output logic [INDEX_BITS-1:0] lookup_index,
  output logic [INDEX_BITS-1:0] update_index,
  output bpred_pkg::counter_e   pred_counter
);
  import rv_pkg::*;
  import bpred_pkg::*;

  localparam int ENTRIES  = 1 << INDEX_BITS;
  localparam int WORD_LSB = $clog2(WORD_BYTES);

  logic [INDEX_BITS-1:0] history;
  counter_e              counters [ENTRIES];
  counter_e              cur_counter;
  counter_e              next_counter;

  assign lookup_index = fetch_pc[WORD_LSB +: INDEX_BITS] ^ history;
  assign update_index = update.pc[WORD_LSB +: INDEX_BITS] ^ history;
  assign pred_counter = counters[lookup_index];
  assign cur_counter  = counters[update_index];

  // counter transitions, note the jump from weakly_not straight to strong
  always_comb begin
    next_counter = cur_counter;
    if (update.taken) begin
      case (cur_counter)
        strongly_not: next_counter = weakly_not;
        weakly_not:   next_counter = strongly_taken;
        default:      next_counter = strongly_taken;
      endcase
    end else begin
      if (cur_counter == strongly_taken)
        next_counter = weakly_taken;
      else
        next_counter = strongly_not;  // any other state drops all the way
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      history <= '0;
      for (int i = 0; i < ENTRIES; i++)
        counters[i] <= strongly_not;
    end else if (update.valid) begin
      history                <= (history << 1) | INDEX_BITS'(update.taken);
      counters[update_index] <= next_counter;
    end
  end

  assert property (@(posedge clk) reset |=> history == '0)
    else $error("history not cleared after reset");

  // the indexed counter must hold when no resolve writes the table
  assert property (@(posedge clk) disable iff (reset)
    !update.valid |=> counters[$past(update_index)] == $past(counters[update_index]))
    else $error("counter changed without a valid update");

endmodule

// ==== src/branch_resolve.sv ====
// ####################################################################
// branch_resolve
// Works out the real next pc of the instruction in execute, flags a
// misprediction against the pc fetched after it and builds the
// predictor table update.
// ####################################################################

module branch_resolve (
  input  rv_pkg::resolve_t   resolve,
  output bpred_pkg::update_t update,
  output logic               redirect,
  output rv_pkg::xlen_t      redirect_pc
);
  import rv_pkg::*;

  xlen_t target;
  logic  taken;
  logic  is_ctrl;

  always_comb begin
    taken   = 1'b0;
    is_ctrl = 1'b1;
    target  = resolve.pc + WORD_BYTES;  // fall through by default
    case (resolve.opcode)
      jal_op: begin
        taken  = 1'b1;
        target = resolve.pc + resolve.imm;
      end
      jalr_op: begin
        taken  = 1'b1;
        target = resolve.rs1_data + resolve.imm;  // register relative
      end
      branch_op: begin
        taken = resolve.bcond;
        if (resolve.bcond)
          target = resolve.pc + resolve.imm;
      end
      default:
        is_ctrl = 1'b0;  // plain instruction, no table write
    endcase
  end

  // non-control instructions can still redirect if fetch went elsewhere
  assign redirect    = resolve.valid && (target != resolve.next_pc);
  assign redirect_pc = target;

  assign update = '{
    valid:  resolve.valid && is_ctrl,
    taken:  taken,
    pc:     resolve.pc,
    target: target
  };

endmodule

// ==== src/bpred_pkg.sv ====
// ####################################################################
// bpred_pkg
// Predictor table types: two-bit counter states, the update bundle
// from resolution and the lookup bundle handed to the fetch side.
// ####################################################################

package bpred_pkg;

  // log2 of the table depth, also the history length
  localparam int DEFAULT_INDEX_BITS = 5;

  // saturating counter, upper half predicts taken
  typedef enum logic [1:0] {
    strongly_not   = 2'b00,
    weakly_not     = 2'b01,
    weakly_taken   = 2'b10,
    strongly_taken = 2'b11
  } counter_e;

  // table write request, one per resolved control transfer
  typedef struct packed {
    logic          valid;   // jal, jalr or conditional branch
    logic          taken;
    rv_pkg::xlen_t pc;      // pc of the resolved instruction
    rv_pkg::xlen_t target;  // real next pc
  } update_t;

  // combined result of both table lookups at fetch
  typedef struct packed {
    logic          hit;      // btb entry valid and tag matches
    counter_e      counter;
    rv_pkg::xlen_t target;
  } lookup_t;

endpackage

// ==== src/rv_pkg.sv ====
// ####################################################################
// rv_pkg
// Instruction-set facts seen by the branch predictor: machine word,
// control-transfer opcodes and the execute-stage resolve bundle.
// ####################################################################

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;

  // pc step of one instruction
  localparam xlen_t WORD_BYTES = 32'd4;

  // seven-bit major opcode field, only the values the predictor cares about
  typedef enum logic [6:0] {
    jal_op    = 7'b1101111,
    jalr_op   = 7'b1100111,
    branch_op = 7'b1100011,
    other_op  = 7'b0010011  // any non-control instruction
  } opcode_e;

  // one instruction leaving execute
  typedef struct packed {
    logic    valid;     // instruction present this cycle
    opcode_e opcode;
    xlen_t   pc;
    xlen_t   rs1_data;  // jalr base
    xlen_t   imm;
    logic    bcond;     // branch condition from the alu
    xlen_t   next_pc;   // what fetch actually followed with
  } resolve_t;

endpackage
